//--- build.f
+incdir+common
+incdir+tests
common/tsconf_pkg.sv
clocking/clock_phases.sv
clocking/zclock.sv
design/resetter.sv
design/zsignals.sv
ports/zports.sv
design/tsconf_top.sv
tests/tb_tsconf.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP := tb_tsconf
FILELIST := build.f
OBJDIR := obj_dir
BIN := $(OBJDIR)/V$(TOP)
LOG := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh tests/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tests/tb_z80_bus.svh
`ifndef TB_Z80_BUS_SVH
`define TB_Z80_BUS_SVH

task automatic wait_zclk_rises(input int n);
	repeat (n) @(posedge clkz_out);
	#1;
endtask

// one z80 i/o or int acknowledge cycle, pins held for BUS_HOLD clocks
task automatic bus_cycle(input tsconf_pkg::zaddr_t addr, input logic is_rd,
		input logic is_wr, input logic is_m1, input tsconf_pkg::zdata_t wdata,
		output tsconf_pkg::zdata_t rdata);
	@(posedge fclk);
	#1;
	bus_busy = 1'b1;
	a = addr;
	d_in = wdata;
	iorq_n = 1'b0;
	rd_n = ~is_rd;
	wr_n = ~is_wr;
	m1_n = ~is_m1;
	wait_zclk_rises(BUS_HOLD);
	rdata = d_out;
	if (is_wr)
		check_value("d_ena in write", 0, d_ena);
	else
		check_value("d_ena in read", 1, d_ena);
	iorq_n = 1'b1;
	rd_n = 1'b1;
	wr_n = 1'b1;
	m1_n = 1'b1;
	// levels drop at the next zpos
	wait_zclk_rises(1);
	bus_busy = 1'b0;
endtask

task automatic io_write(input tsconf_pkg::zaddr_t addr, input tsconf_pkg::zdata_t data);
	tsconf_pkg::zdata_t unused;
	bus_cycle(addr, 1'b0, 1'b1, 1'b0, data, unused);
endtask

task automatic io_read(input tsconf_pkg::zaddr_t addr, output tsconf_pkg::zdata_t data);
	bus_cycle(addr, 1'b1, 1'b0, 1'b0, 8'h00, data);
endtask

task automatic int_ack(output tsconf_pkg::zdata_t data);
	bus_cycle(16'h0000, 1'b0, 1'b0, 1'b1, 8'h00, data);
endtask

`endif

//--- tests/tb_tsconf.sv
`timescale 1ns/1ps
`include "tsconf_settings.svh"

module tb_tsconf;

	localparam int RESET_CYCLES = 8;
	localparam int STRETCH_CYCLES = 1 << `RST_CNT_SIZE;
	// reset stretch and bus cycles at 3.5 MHz plus clock measurements and margin
	localparam int WATCHDOG_CYCLES = 4000;
	localparam int BUS_HOLD = 4;
	localparam int SETTLE_CYCLES = 16;

	logic fclk = 1'b0;
	logic rst_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	logic tape_in;
	tsconf_pkg::zaddr_t a;
	tsconf_pkg::zdata_t d_in;
	tsconf_pkg::zdata_t d_out;
	logic d_ena;
	logic clkz_out;
	logic res;
	logic ay_clk;
	logic beep;
	tsconf_pkg::border_t border;

	logic bus_busy;
	logic [31:0] rng = 32'd34;
	int errors = 0;
	int checks = 0;

	always #2 fclk = ~fclk;

	tsconf_top uut (
		.fclk(fclk),
		.rst_n(rst_n),
		.iorq_n(iorq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.m1_n(m1_n),
		.tape_in(tape_in),
		.a(a),
		.d_in(d_in),
		.d_out(d_out),
		.d_ena(d_ena),
		.clkz_out(clkz_out),
		.res(res),
		.ay_clk(ay_clk),
		.beep(beep),
		.border(border)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic probe(input logic use_ay);
		return use_ay ? ay_clk : clkz_out;
	endfunction

	task automatic next_cycle();
		@(posedge fclk);
		#1;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// high time and period in fclk cycles between rising edges
	task automatic measure_clock(input logic use_ay, output int high, output int period);
		int low;
		high = 0;
		low = 0;
		while (probe(use_ay))
			next_cycle();
		while (!probe(use_ay))
			next_cycle();
		while (probe(use_ay)) begin
			high++;
			next_cycle();
		end
		while (!probe(use_ay)) begin
			low++;
			next_cycle();
		end
		period = high + low;
	endtask

	`include "tb_z80_bus.svh"

	//////////////////////////////////////////////////
	// checkers

	a_quiet_in_reset: assert property (@(posedge fclk)
		(rst_n && res) |-> !(clkz_out || ay_clk || beep || d_ena))
	else begin
		errors++;
		$display("an output was active while res was still high");
	end

	a_bus_idle: assert property (@(posedge fclk) !bus_busy |-> !d_ena)
	else begin
		errors++;
		$display("d_ena was high outside a bus cycle");
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		int n;
		int high;
		int period;
		tsconf_pkg::zdata_t rdata;
		tsconf_pkg::zdata_t val;
		tsconf_pkg::zdata_t expected;
		rst_n = 1'b0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		tape_in = 1'b0;
		a = '0;
		d_in = '0;
		bus_busy = 1'b0;
		n = 0;
		repeat (RESET_CYCLES) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		while (n <= 2 * STRETCH_CYCLES) begin
			next_cycle();
			if (!res)
				break;
			n++;
		end
		check_value("reset stretch", STRETCH_CYCLES, n);

		// power-up speed and sound clock
		measure_clock(1'b0, high, period);
		check_value("zclk period 3.5 MHz", 8, period);
		check_value("zclk high 3.5 MHz", 4, high);
		measure_clock(1'b1, high, period);
		check_value("ay_clk high slow", `AY_DIV_SLOW, high);
		check_value("ay_clk low slow", `AY_DIV_SLOW, period - high);

		int_ack(rdata);
		check_value("im2 vector after reset", 8'hFF, rdata);

		// a value and its complement so every border and beep bit moves
		rng = xorshift(rng);
		for (int w = 0; w < 2; w++) begin
			val = w[0] ? ~rng[7:0] : rng[7:0];
			io_write({rng[15:8], `PORT_FE}, val);
			check_value("border", {29'd0, val[2:0]}, {29'd0, border});
			check_value("beep", {31'd0, val[4]}, {31'd0, beep});
		end
		for (int t = 0; t < 2; t++) begin
			tape_in = t[0];
			expected = 8'hFF;
			expected[6] = t[0];
			io_read({8'h00, `PORT_FE}, rdata);
			check_value("read #FE", expected, rdata);
		end

		rng = xorshift(rng);
		val = rng[7:0];
		io_write(`PORT_IM2VECT, val);
		int_ack(rdata);
		check_value("im2 vector written", val, rdata);

		// turbo 01, ay_div 0
		rng = xorshift(rng);
		val = {rng[7:3], 1'b0, 2'b01};
		io_write(`PORT_SYSCONF, val);
		repeat (SETTLE_CYCLES) next_cycle();
		measure_clock(1'b0, high, period);
		check_value("zclk period 7 MHz", 4, period);
		check_value("zclk high 7 MHz", 2, high);
		io_read(`PORT_SYSCONF, rdata);
		check_value("read sysconf", val, rdata);

		// turbo 10, ay_div 1
		rng = xorshift(rng);
		val = {rng[7:3], 1'b1, 2'b10};
		io_write(`PORT_SYSCONF, val);
		repeat (SETTLE_CYCLES) next_cycle();
		measure_clock(1'b0, high, period);
		check_value("zclk period 14 MHz", 2, period);
		check_value("zclk high 14 MHz", 1, high);
		measure_clock(1'b1, high, period);
		check_value("ay_clk high fast", `AY_DIV_FAST, high);
		check_value("ay_clk low fast", `AY_DIV_FAST, period - high);
		io_read(`PORT_SYSCONF, rdata);
		check_value("read sysconf", val, rdata);

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fclk);
		$display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- design/tsconf_top.sv
`timescale 1ns/1ps

module tsconf_top (
	input logic fclk,
	input logic rst_n,
	input logic iorq_n,
	input logic rd_n,
	input logic wr_n,
	input logic m1_n,
	input logic tape_in,
	input tsconf_pkg::zaddr_t a,
	input tsconf_pkg::zdata_t d_in,
	output tsconf_pkg::zdata_t d_out,
	output logic d_ena,
	output logic clkz_out,
	output logic res,
	output logic ay_clk,
	output logic beep,
	output tsconf_pkg::border_t border
);

	logic sys_rst_n;
	logic zpos;
	tsconf_pkg::phase_t phases;
	tsconf_pkg::zctl_t ctl;
	tsconf_pkg::zstb_t stb;
	tsconf_pkg::sysconf_t sysconf;
	tsconf_pkg::zdata_t im2vect;
	tsconf_pkg::zdata_t port_dout;
	logic port_ena;

	resetter myrst (
		.fclk(fclk),
		.rst_n(rst_n),
		.sys_rst_n(sys_rst_n)
	);

	assign res = ~sys_rst_n;

	clock_phases clock (
		.fclk(fclk),
		.rst_n(sys_rst_n),
		.ay_div(sysconf.ay_div),
		.phases(phases),
		.ay_clk(ay_clk)
	);

	// zneg only shapes clkz_out inside the generator
	zclock zclock (
		.fclk(fclk),
		.rst_n(sys_rst_n),
		.phases(phases),
		.turbo(sysconf.turbo),
		.zclk_out(clkz_out),
		.zpos(zpos),
		.zneg()
	);

	zsignals zsignals (
		.fclk(fclk),
		.rst_n(sys_rst_n),
		.zpos(zpos),
		.iorq_n(iorq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.m1_n(m1_n),
		.ctl(ctl),
		.stb(stb)
	);

	zports zports (
		.fclk(fclk),
		.rst_n(sys_rst_n),
		.a(a),
		.din(d_in),
		.tape_in(tape_in),
		.ctl(ctl),
		.stb(stb),
		.sysconf(sysconf),
		.border(border),
		.beep(beep),
		.im2vect(im2vect),
		.port_dout(port_dout),
		.port_ena(port_ena)
	);

	////////////////////////////////////////////////////
	// data bus

	// port readback wins, vector only during int acknowledge
	assign d_out = port_ena ? port_dout : im2vect;
	assign d_ena = port_ena | ctl.intack;

endmodule

//--- ports/zports.sv
`timescale 1ns/1ps
`include "tsconf_settings.svh"

module zports (
	input logic fclk,
	input logic rst_n,
	input tsconf_pkg::zaddr_t a,
	input tsconf_pkg::zdata_t din,
	input logic tape_in,
	input tsconf_pkg::zctl_t ctl,
	input tsconf_pkg::zstb_t stb,
	output tsconf_pkg::sysconf_t sysconf,
	output tsconf_pkg::border_t border,
	output logic beep,
	output tsconf_pkg::zdata_t im2vect,
	output tsconf_pkg::zdata_t port_dout,
	output logic port_ena
);

	logic hit_fe;
	logic hit_sysconf;
	logic hit_im2vect;

	////////////////////////////////////////////////////
	// address decode

	assign hit_fe = (a[7:0] == `PORT_FE);
	assign hit_sysconf = (a == `PORT_SYSCONF);
	assign hit_im2vect = (a == `PORT_IM2VECT);

	////////////////////////////////////////////////////
	// port registers

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			border <= '0;
			beep <= 1'b0;
		end else if (stb.iowr_s && hit_fe) begin
			border <= din[2:0];
			beep <= din[4];
		end
	end

	always_ff @(posedge fclk) begin
		if (!rst_n)
			sysconf <= '0;
		else if (stb.iowr_s && hit_sysconf)
			sysconf <= tsconf_pkg::sysconf_t'(din);
	end

	always_ff @(posedge fclk) begin
		if (!rst_n)
			im2vect <= `IM2VECT_RESET;
		else if (stb.iowr_s && hit_im2vect)
			im2vect <= din;
	end

	////////////////////////////////////////////////////
	// readback

	// #FE reads all ones except the tape input on bit 6
	assign port_ena = ctl.iord & (hit_fe | hit_sysconf);
	assign port_dout = hit_fe ? {1'b1, tape_in, 6'h3F} : tsconf_pkg::zdata_t'(sysconf);

	// readback and vector never compete for the bus
	a_no_read_in_intack: assert property (@(posedge fclk) disable iff (!rst_n)
		port_ena |-> !ctl.intack);

endmodule

//--- design/zsignals.sv
`timescale 1ns/1ps

module zsignals (
	input logic fclk,
	input logic rst_n,
	input logic zpos,
	input logic iorq_n,
	input logic rd_n,
	input logic wr_n,
	input logic m1_n,
	output tsconf_pkg::zctl_t ctl,
	output tsconf_pkg::zstb_t stb
);

	logic iorq;
	logic rd;
	logic wr;
	logic m1;
	logic iord_d;
	logic iowr_d;

	// pins sampled at the rising z80 clock
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			iorq <= 1'b0;
			rd <= 1'b0;
			wr <= 1'b0;
			m1 <= 1'b0;
		end else if (zpos) begin
			iorq <= ~iorq_n;
			rd <= ~rd_n;
			wr <= ~wr_n;
			m1 <= ~m1_n;
		end
	end

	always_comb begin
		ctl.iorq = iorq;
		ctl.rd = rd;
		ctl.wr = wr;
		ctl.m1 = m1;
		ctl.iord = iorq & rd;
		ctl.iowr = iorq & wr;
		ctl.intack = iorq & m1;
	end

	////////////////////////////////////////////////////
	// edge strobes

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			iord_d <= 1'b0;
			iowr_d <= 1'b0;
		end else begin
			iord_d <= ctl.iord;
			iowr_d <= ctl.iowr;
		end
	end

	assign stb.iord_s = ctl.iord & ~iord_d;
	assign stb.iowr_s = ctl.iowr & ~iowr_d;

	// level outlives its strobe
	a_iowr_strobe: assert property (@(posedge fclk) disable iff (!rst_n)
		stb.iowr_s |=> ctl.iowr && !stb.iowr_s);

endmodule

//--- design/resetter.sv
`timescale 1ns/1ps
`include "tsconf_settings.svh"

module resetter (
	input logic fclk,
	input logic rst_n,
	output logic sys_rst_n
);

	tsconf_pkg::rst_state_t state;
	logic [`RST_CNT_SIZE-1:0] cnt;

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state <= tsconf_pkg::HOLD;
			cnt <= '0;
			sys_rst_n <= 1'b0;
		end else begin
			case (state)
				tsconf_pkg::HOLD: begin
					cnt <= cnt + 1'b1;
					sys_rst_n <= 1'b0;
					if (&cnt)
						state <= tsconf_pkg::RUN;
				end
				default: begin
					sys_rst_n <= 1'b1;
				end
			endcase
		end
	end

	a_no_early_release: assert property (@(posedge fclk)
		sys_rst_n |-> state == tsconf_pkg::RUN);

endmodule

//--- clocking/zclock.sv
`timescale 1ns/1ps

module zclock (
	input logic fclk,
	input logic rst_n,
	input tsconf_pkg::phase_t phases,
	input tsconf_pkg::turbo_t turbo,
	output logic zclk_out,
	output logic zpos,
	output logic zneg
);

	tsconf_pkg::turbo_t turbo_q;
	logic half;

	// speed changes only at the end of a phase round
	always_ff @(posedge fclk) begin
		if (!rst_n)
			turbo_q <= 2'b00;
		else if (phases.c3)
			turbo_q <= turbo;
	end

	// picks high or low half in 3.5 MHz mode
	always_ff @(posedge fclk) begin
		if (!rst_n)
			half <= 1'b0;
		else if (phases.c0)
			half <= ~half;
	end

	always_comb begin
		case (turbo_q)
			2'b00: begin
				zpos = phases.c0 & ~half;
				zneg = phases.c0 & half;
			end
			2'b01: begin
				zpos = phases.c0;
				zneg = phases.c2;
			end
			default: begin
				zpos = phases.f0;
				zneg = phases.f1;
			end
		endcase
	end

	always_ff @(posedge fclk) begin
		if (!rst_n)
			zclk_out <= 1'b0;
		else if (zpos)
			zclk_out <= 1'b1;
		else if (zneg)
			zclk_out <= 1'b0;
	end

	a_edges_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
		!(zpos && zneg));

endmodule

//--- clocking/clock_phases.sv
`timescale 1ns/1ps
`include "tsconf_settings.svh"

module clock_phases (
	input logic fclk,
	input logic rst_n,
	input logic ay_div,
	output tsconf_pkg::phase_t phases,
	output logic ay_clk
);

	localparam int AY_CNT_W = $clog2(`AY_DIV_SLOW);
	localparam logic [AY_CNT_W-1:0] AY_LAST_SLOW = AY_CNT_W'(`AY_DIV_SLOW - 1);
	localparam logic [AY_CNT_W-1:0] AY_LAST_FAST = AY_CNT_W'(`AY_DIV_FAST - 1);

	logic [1:0] cnt;
	logic [AY_CNT_W-1:0] ay_cnt;
	logic [AY_CNT_W-1:0] ay_last;

	always_ff @(posedge fclk) begin
		if (!rst_n)
			cnt <= 2'd0;
		else
			cnt <= cnt + 2'd1;
	end

	always_comb begin
		phases.c0 = (cnt == 2'd0);
		phases.c1 = (cnt == 2'd1);
		phases.c2 = (cnt == 2'd2);
		phases.c3 = (cnt == 2'd3);
		phases.f0 = ~cnt[0];
		phases.f1 = cnt[0];
	end

	////////////////////////////////////////////////////
	// sound chip clock

	assign ay_last = ay_div ? AY_LAST_FAST : AY_LAST_SLOW;

	// >= so a switch to the fast divider mid count does not wrap
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			ay_cnt <= '0;
			ay_clk <= 1'b0;
		end else if (ay_cnt >= ay_last) begin
			ay_cnt <= '0;
			ay_clk <= ~ay_clk;
		end else begin
			ay_cnt <= ay_cnt + 1'b1;
		end
	end

	a_phase_onehot: assert property (@(posedge fclk) disable iff (!rst_n)
		$onehot({phases.c0, phases.c1, phases.c2, phases.c3}));

endmodule

//--- common/tsconf_pkg.sv
package tsconf_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;
	// 00 3.5 MHz, 01 7 MHz, 1x 14 MHz
	typedef logic [1:0] turbo_t;
	typedef logic [2:0] border_t;

	typedef struct packed {
		logic c0;
		logic c1;
		logic c2;
		logic c3;
		logic f0;
		logic f1;
	} phase_t;

	typedef struct packed {
		logic iorq;
		logic rd;
		logic wr;
		logic m1;
		logic iord;
		logic iowr;
		logic intack;
	} zctl_t;

	typedef struct packed {
		logic iord_s;
		logic iowr_s;
	} zstb_t;

	// turbo kept in bits 1:0 as on the real board
	typedef struct packed {
		logic [4:0] rsvd;
		logic ay_div;
		turbo_t turbo;
	} sysconf_t;

	typedef enum logic {
		HOLD,
		RUN
	} rst_state_t;

endpackage

//--- common/tsconf_settings.svh
`ifndef TSCONF_SETTINGS_SVH
`define TSCONF_SETTINGS_SVH

// reset stretch counter width, 2**6 fclk cycles
`define RST_CNT_SIZE 6

// port addresses
// border and beeper, decoded on the low byte only
`define PORT_FE 8'hFE
`define PORT_SYSCONF 16'h20AF
`define PORT_IM2VECT 16'h0FAF

// power-up value of the vector byte
`define IM2VECT_RESET 8'hFF

// ay_clk half periods in fclk cycles
`define AY_DIV_SLOW 16
`define AY_DIV_FAST 8

`endif
